// ==== compile.f ====
rtl/memsys_pkg.sv
rtl/mem_req_if.sv
rtl/mem_rsp_if.sv
rtl/bus_req_decode.sv
rtl/mem_access_exec.sv
rtl/bus_resp_gen.sv
rtl/memsys_top.sv
testbench/memsys_checker.sv
testbench/tb_memsys.sv

// ==== Bender.yml ====
package:
  name: memsys

sources:
  - rtl/memsys_pkg.sv
  - rtl/mem_req_if.sv
  - rtl/mem_rsp_if.sv
  - rtl/bus_req_decode.sv
  - rtl/mem_access_exec.sv
  - rtl/bus_resp_gen.sv
  - rtl/memsys_top.sv
  - target: test
    files:
      - testbench/memsys_checker.sv
      - testbench/tb_memsys.sv

// ==== testbench/tb_memsys.sv ====
module tb_memsys;

  localparam int NUM_ENTRIES = 16;
  localparam memsys_pkg::resp_t OK  = memsys_pkg::RESP_OKAY;
  localparam memsys_pkg::resp_t DEC = memsys_pkg::RESP_DECERR;

  logic              clk;
  logic              rst_n_i;
  logic              ar_valid_i, ar_ready_o, r_valid_o, r_ready_i;
  logic              aw_valid_i, aw_ready_o, w_valid_i, w_ready_o, b_valid_o, b_ready_i;
  logic              uart_tx_valid_o;
  logic [7:0]        uart_tx_data_o;
  memsys_pkg::addr_t ar_addr_i, aw_addr_i;
  memsys_pkg::id_t   ar_id_i, aw_id_i, r_id_o, b_id_o;
  memsys_pkg::data_t w_data_i, r_data_o;
  memsys_pkg::strb_t w_strb_i;
  memsys_pkg::resp_t r_resp_o, b_resp_o;

  // stimulus and expected values, one entry per access
  string       t_name [NUM_ENTRIES];
  logic        t_wr [NUM_ENTRIES], t_pair [NUM_ENTRIES];
  logic [31:0] t_addr [NUM_ENTRIES], t_wdata [NUM_ENTRIES], t_rdata [NUM_ENTRIES];
  logic [3:0]  t_strb [NUM_ENTRIES], t_id [NUM_ENTRIES];
  logic [1:0]  t_resp [NUM_ENTRIES];
  int          t_uart [NUM_ENTRIES];
  int          n_entries = 0;
  int          n_checks = 0;
  int          n_errors = 0;
  int          uart_cnt = 0;
  logic [7:0]  uart_byte;
  logic [31:0] rng = 32'hf5b6_f23a;

  memsys_top #(.MEM_WORDS(256), .STALL_EN(1'b1)) DUT (.*);

  bind memsys_top memsys_checker u_checker (.*);

  always #5 clk = ~clk;

  // transmit pulses sampled mid-cycle
  always @(negedge clk) begin
    if (uart_tx_valid_o) begin
      uart_cnt++;
      uart_byte = uart_tx_data_o;
    end
  end

  // lcg draw gives a ready delay of 0 to 3 cycles
  function automatic int next_delay();
    rng = rng * 32'd1664525 + 32'd1013904223;
    return int'(rng[31:30]);
  endfunction

  task automatic add_entry(string name, logic wr, logic [31:0] addr, logic [31:0] wdata,
                           logic [3:0] strb, logic [3:0] id, logic [31:0] rdata,
                           logic [1:0] resp, int uart, logic pair);
    t_name[n_entries]  = name;
    t_wr[n_entries]    = wr;
    t_addr[n_entries]  = addr;
    t_wdata[n_entries] = wdata;
    t_strb[n_entries]  = strb;
    t_id[n_entries]    = id;
    t_rdata[n_entries] = rdata;
    t_resp[n_entries]  = resp;
    t_uart[n_entries]  = uart;
    t_pair[n_entries]  = pair;
    n_entries++;
  endtask

  task automatic check_value(string test, string field, logic [31:0] expected,
                             logic [31:0] actual);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("ERROR %s %s: expected %h, actual %h", test, field, expected, actual);
    end
  endtask

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic raise_read(int i);
    ar_valid_i = 1'b1;
    ar_addr_i  = t_addr[i];
    ar_id_i    = t_id[i];
  endtask

  task automatic raise_write(int i);
    aw_valid_i = 1'b1;
    w_valid_i  = 1'b1;
    aw_addr_i  = t_addr[i];
    aw_id_i    = t_id[i];
    w_data_i   = t_wdata[i];
    w_strb_i   = t_strb[i];
  endtask

  // hold the request until its address handshake
  task automatic finish_request(logic wr);
    @(negedge clk);
    while (wr ? !(aw_ready_o && w_ready_o) : !ar_ready_o) @(negedge clk);
    step();
    if (wr) begin
      aw_valid_i = 1'b0;
      w_valid_i  = 1'b0;
    end else begin
      ar_valid_i = 1'b0;
    end
  endtask

  // wait for the response and compare, then hold ready back for a random delay
  task automatic take_response(int i);
    uart_cnt = 0;
    step();
    while (!(t_wr[i] ? b_valid_o : r_valid_o)) step();
    if (t_wr[i]) begin
      check_value(t_name[i], "b_resp", t_resp[i], b_resp_o);
      check_value(t_name[i], "b_id", t_id[i], b_id_o);
    end else begin
      check_value(t_name[i], "r_data", t_rdata[i], r_data_o);
      check_value(t_name[i], "r_resp", t_resp[i], r_resp_o);
      check_value(t_name[i], "r_id", t_id[i], r_id_o);
    end
    check_value(t_name[i], "uart_pulses", (t_uart[i] < 0) ? 0 : 1, uart_cnt);
    if (t_uart[i] >= 0) check_value(t_name[i], "uart_byte", t_uart[i], uart_byte);
    repeat (next_delay()) step();
    if (t_wr[i]) b_ready_i = 1'b1;
    else r_ready_i = 1'b1;
    step();
    b_ready_i = 1'b0;
    r_ready_i = 1'b0;
  endtask

  initial begin
    clk        = 1'b0;
    rst_n_i    = 1'b0;
    ar_valid_i = 1'b0;
    ar_addr_i  = '0;
    ar_id_i    = '0;
    aw_valid_i = 1'b0;
    aw_addr_i  = '0;
    aw_id_i    = '0;
    w_valid_i  = 1'b0;
    w_data_i   = '0;
    w_strb_i   = '0;
    r_ready_i  = 1'b0;
    b_ready_i  = 1'b0;
    // partial write replaces bytes 0 and 2 of dead_beef
    add_entry("wr_full", 1, 32'h8000_0000, 32'hdead_beef, 4'hf, 4'h1, 32'h0, OK, -1, 0);
    add_entry("rd_full", 0, 32'h8000_0000, 32'h0, 4'h0, 4'h2, 32'hdead_beef, OK, -1, 0);
    add_entry("wr_part", 1, 32'h8000_0000, 32'h1122_3344, 4'h5, 4'h3, 32'h0, OK, -1, 0);
    add_entry("rd_part", 0, 32'h8000_0000, 32'h0, 4'h0, 4'h4, 32'hde22_be44, OK, -1, 0);
    add_entry("wr_last", 1, 32'h8000_03fc, 32'hcafe_f00d, 4'hf, 4'h5, 32'h0, OK, -1, 0);
    add_entry("wr_uart", 1, 32'ha000_03f8, 32'h1234_5641, 4'hf, 4'h6, 32'h0, OK, 'h41, 0);
    add_entry("rd_uart", 0, 32'ha000_03f8, 32'h0, 4'h0, 4'h7, 32'h0, OK, -1, 0);
    add_entry("wr_past", 1, 32'h8000_0400, 32'hffff_ffff, 4'hf, 4'h8, 32'h0, DEC, -1, 0);
    add_entry("rd_past", 0, 32'h8000_0400, 32'h0, 4'h0, 4'h9, 32'h0, DEC, -1, 0);
    add_entry("wr_none", 1, 32'h1000_0000, 32'h1234_5678, 4'hf, 4'ha, 32'h0, DEC, -1, 0);
    add_entry("rd_none", 0, 32'h7fff_fffc, 32'h0, 4'h0, 4'hb, 32'h0, DEC, -1, 0);
    add_entry("rd_last", 0, 32'h8000_03fc, 32'h0, 4'h0, 4'hc, 32'hcafe_f00d, OK, -1, 0);
    add_entry("rd_keep", 0, 32'h8000_0000, 32'h0, 4'h0, 4'hd, 32'hde22_be44, OK, -1, 0);
    add_entry("pair_rd", 0, 32'h8000_03fc, 32'h0, 4'h0, 4'he, 32'hcafe_f00d, OK, -1, 1);
    add_entry("pair_wr", 1, 32'h8000_0020, 32'ha5a5_5a5a, 4'hf, 4'hf, 32'h0, OK, -1, 0);
    add_entry("rd_pair", 0, 32'h8000_0020, 32'h0, 4'h0, 4'h0, 32'ha5a5_5a5a, OK, -1, 0);
    repeat (16) @(posedge clk);
    #1;
    rst_n_i = 1'b1;
    for (int i = 0; i < n_entries; i++) begin
      if (t_pair[i]) begin
        // read and write offered in the same cycle so the read goes first
        raise_write(i + 1);
        raise_read(i);
        @(negedge clk);
        check_value(t_name[i], "ar_ready", 1, ar_ready_o);
        check_value(t_name[i], "aw_ready", 0, aw_ready_o);
        step();
        ar_valid_i = 1'b0;
        take_response(i);
        i++;
        finish_request(1'b1);
        take_response(i);
      end else begin
        if (t_wr[i]) raise_write(i);
        else raise_read(i);
        finish_request(t_wr[i]);
        take_response(i);
      end
    end
    step();
    $display("checks: %0d, errors: %0d, assertion failures: %0d",
             n_checks, n_errors, DUT.u_checker.fail_cnt);
    if (n_errors == 0 && DUT.u_checker.fail_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // watchdog allows 64 cycles per table entry
  initial begin
    repeat (NUM_ENTRIES * 64) @(posedge clk);
    $display("timeout: the DUT did not finish the test table within %0d cycles",
             NUM_ENTRIES * 64);
    $display("sim failed");
    $finish;
  end

endmodule

// ==== testbench/memsys_checker.sv ====
module memsys_checker (
  input logic              clk,
  input logic              rst_n_i,
  input logic              ar_ready_o,
  input logic              r_valid_o,
  input logic              r_ready_i,
  input memsys_pkg::data_t r_data_o,
  input memsys_pkg::resp_t r_resp_o,
  input memsys_pkg::id_t   r_id_o,
  input logic              b_valid_o,
  input logic              b_ready_i,
  input memsys_pkg::resp_t b_resp_o,
  input memsys_pkg::id_t   b_id_o,
  input logic              uart_tx_valid_o
);

  int fail_cnt = 0;

  // read response held until r_ready
  r_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable({r_data_o, r_resp_o, r_id_o})
  ) else begin
    fail_cnt++;
    $error("read response dropped or changed before r_ready");
  end

  // write response held until b_ready
  b_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    b_valid_o && !b_ready_i |=> b_valid_o && $stable({b_resp_o, b_id_o})
  ) else begin
    fail_cnt++;
    $error("write response dropped or changed before b_ready");
  end

  rb_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
    !(r_valid_o && b_valid_o)
  ) else begin
    fail_cnt++;
    $error("read and write responses valid together");
  end

  // no new read accepted while a response waits
  ar_block: assert property (@(posedge clk) disable iff (!rst_n_i)
    r_valid_o || b_valid_o |-> !ar_ready_o
  ) else begin
    fail_cnt++;
    $error("ar_ready high with a response pending");
  end

  uart_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
    uart_tx_valid_o |=> !uart_tx_valid_o
  ) else begin
    fail_cnt++;
    $error("uart transmit strobe longer than one cycle");
  end

endmodule

// ==== rtl/memsys_top.sv ====
module memsys_top #(
  parameter int MEM_WORDS = 256,
  parameter bit STALL_EN  = 1'b1
) (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              ar_valid_i,
  output logic              ar_ready_o,
  input  memsys_pkg::addr_t ar_addr_i,
  input  memsys_pkg::id_t   ar_id_i,
  output logic              r_valid_o,
  input  logic              r_ready_i,
  output memsys_pkg::data_t r_data_o,
  output memsys_pkg::resp_t r_resp_o,
  output memsys_pkg::id_t   r_id_o,
  input  logic              aw_valid_i,
  output logic              aw_ready_o,
  input  memsys_pkg::addr_t aw_addr_i,
  input  memsys_pkg::id_t   aw_id_i,
  input  logic              w_valid_i,
  output logic              w_ready_o,
  input  memsys_pkg::data_t w_data_i,
  input  memsys_pkg::strb_t w_strb_i,
  output logic              b_valid_o,
  input  logic              b_ready_i,
  output memsys_pkg::resp_t b_resp_o,
  output memsys_pkg::id_t   b_id_o,
  output logic              uart_tx_valid_o,
  output logic [7:0]        uart_tx_data_o
);

  logic rsp_done;

  mem_req_if #(.MEM_WORDS(MEM_WORDS)) req_if ();
  mem_rsp_if rsp_if ();

  // decode -> execute -> response
  bus_req_decode #(.MEM_WORDS(MEM_WORDS)) u_decode (
    .clk, .rst_n_i,
    .ar_valid_i, .ar_ready_o, .ar_addr_i, .ar_id_i,
    .aw_valid_i, .aw_ready_o, .aw_addr_i, .aw_id_i,
    .w_valid_i, .w_ready_o, .w_data_i, .w_strb_i,
    .rsp_done_i (rsp_done),
    .req        (req_if.master)
  );

  mem_access_exec #(.MEM_WORDS(MEM_WORDS), .STALL_EN(STALL_EN)) u_exec (
    .clk, .rst_n_i,
    .req (req_if.slave),
    .rsp (rsp_if.master),
    .uart_tx_valid_o, .uart_tx_data_o
  );

  bus_resp_gen u_resp (
    .clk, .rst_n_i,
    .rsp        (rsp_if.slave),
    .r_valid_o, .r_ready_i, .r_data_o, .r_resp_o, .r_id_o,
    .b_valid_o, .b_ready_i, .b_resp_o, .b_id_o,
    .rsp_done_o (rsp_done)
  );

endmodule

// ==== rtl/bus_resp_gen.sv ====
module bus_resp_gen (
  input  logic              clk,
  input  logic              rst_n_i,
  mem_rsp_if.slave          rsp,
  output logic              r_valid_o,
  input  logic              r_ready_i,
  output memsys_pkg::data_t r_data_o,
  output memsys_pkg::resp_t r_resp_o,
  output memsys_pkg::id_t   r_id_o,
  output logic              b_valid_o,
  input  logic              b_ready_i,
  output memsys_pkg::resp_t b_resp_o,
  output memsys_pkg::id_t   b_id_o,
  output logic              rsp_done_o
);

  logic r_valid_q;
  logic b_valid_q;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      r_valid_q <= 1'b0;
      b_valid_q <= 1'b0;
    end else begin
      if (rsp.rsp_valid && !rsp.rsp_write) r_valid_q <= 1'b1;
      else if (r_ready_i) r_valid_q <= 1'b0;
      if (rsp.rsp_valid && rsp.rsp_write) b_valid_q <= 1'b1;
      else if (b_ready_i) b_valid_q <= 1'b0;
    end
  end

  // payload held stable until the handshake
  always_ff @(posedge clk) begin
    if (rsp.rsp_valid && !rsp.rsp_write) begin
      r_data_o <= rsp.rsp_rdata;
      r_resp_o <= rsp.rsp_resp;
      r_id_o   <= rsp.rsp_id;
    end
    if (rsp.rsp_valid && rsp.rsp_write) begin
      b_resp_o <= rsp.rsp_resp;
      b_id_o   <= rsp.rsp_id;
    end
  end

  assign r_valid_o  = r_valid_q;
  assign b_valid_o  = b_valid_q;
  assign rsp_done_o = (r_valid_q & r_ready_i) | (b_valid_q & b_ready_i);

endmodule

// ==== rtl/mem_access_exec.sv ====
module mem_access_exec #(
  parameter int MEM_WORDS = 256,
  parameter bit STALL_EN  = 1'b1
) (
  input  logic       clk,
  input  logic       rst_n_i,
  mem_req_if.slave   req,
  mem_rsp_if.master  rsp,
  output logic       uart_tx_valid_o,
  output logic [7:0] uart_tx_data_o
);
  localparam int IDX_W = $clog2(MEM_WORDS);

  memsys_pkg::exec_state_e state_q;
  logic [19:0]             lfsr_q;
  logic                    go;
  logic                    hold_write;
  memsys_pkg::region_e     hold_region;
  logic [IDX_W-1:0]        hold_index;
  memsys_pkg::data_t       hold_wdata;
  memsys_pkg::strb_t       hold_wstrb;
  memsys_pkg::id_t         hold_id;
  memsys_pkg::data_t       mem [MEM_WORDS];
  logic                    rsp_valid_q;
  logic                    rsp_write_q;
  memsys_pkg::data_t       rsp_rdata_q;
  memsys_pkg::resp_t       rsp_resp_q;
  memsys_pkg::id_t         rsp_id_q;
  logic                    uart_valid_q;
  logic [7:0]              uart_data_q;

  // access proceeds once the slow-memory model lets it
  assign go = (state_q == memsys_pkg::EXEC_STALL) && (!STALL_EN || lfsr_q[19]);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q      <= memsys_pkg::EXEC_IDLE;
      lfsr_q       <= 20'd101;
      rsp_valid_q  <= 1'b0;
      uart_valid_q <= 1'b0;
    end else begin
      // maximal-length taps 20 and 17
      lfsr_q       <= {lfsr_q[18:0], lfsr_q[19] ^ lfsr_q[16]};
      rsp_valid_q  <= go;
      uart_valid_q <= go && hold_write && (hold_region == memsys_pkg::REGION_UART);
      if (state_q == memsys_pkg::EXEC_IDLE && req.req_valid)
        state_q <= memsys_pkg::EXEC_STALL;
      else if (go)
        state_q <= memsys_pkg::EXEC_IDLE;
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == memsys_pkg::EXEC_IDLE && req.req_valid) begin
      hold_write  <= req.req_write;
      hold_region <= req.req_region;
      hold_index  <= req.req_index;
      hold_wdata  <= req.req_wdata;
      hold_wstrb  <= req.req_wstrb;
      hold_id     <= req.req_id;
    end
    if (go) begin
      rsp_write_q <= hold_write;
      rsp_id_q    <= hold_id;
      rsp_resp_q  <= (hold_region == memsys_pkg::REGION_NONE) ?
                     memsys_pkg::RESP_DECERR : memsys_pkg::RESP_OKAY;
      // uart reads and decode errors return zero
      if (!hold_write && hold_region == memsys_pkg::REGION_SRAM)
        rsp_rdata_q <= mem[hold_index];
      else
        rsp_rdata_q <= '0;
      uart_data_q <= hold_wdata[7:0];
    end
  end

  // byte-strobed sram write
  always_ff @(posedge clk) begin
    if (go && hold_write && hold_region == memsys_pkg::REGION_SRAM) begin
      for (int b = 0; b < 4; b++) begin
        if (hold_wstrb[b]) mem[hold_index][8*b +: 8] <= hold_wdata[8*b +: 8];
      end
    end
  end

  assign rsp.rsp_valid   = rsp_valid_q;
  assign rsp.rsp_write   = rsp_write_q;
  assign rsp.rsp_rdata   = rsp_rdata_q;
  assign rsp.rsp_resp    = rsp_resp_q;
  assign rsp.rsp_id      = rsp_id_q;
  assign uart_tx_valid_o = uart_valid_q;
  assign uart_tx_data_o  = uart_data_q;

endmodule

// ==== rtl/bus_req_decode.sv ====
module bus_req_decode #(
  parameter int MEM_WORDS = 256
) (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              ar_valid_i,
  output logic              ar_ready_o,
  input  memsys_pkg::addr_t ar_addr_i,
  input  memsys_pkg::id_t   ar_id_i,
  input  logic              aw_valid_i,
  output logic              aw_ready_o,
  input  memsys_pkg::addr_t aw_addr_i,
  input  memsys_pkg::id_t   aw_id_i,
  input  logic              w_valid_i,
  output logic              w_ready_o,
  input  memsys_pkg::data_t w_data_i,
  input  memsys_pkg::strb_t w_strb_i,
  input  logic              rsp_done_i,
  mem_req_if.master         req
);
  localparam int IDX_W = $clog2(MEM_WORDS);

  memsys_pkg::dec_state_e state_q;
  memsys_pkg::dec_state_e state_d;
  logic                   idle_q;
  logic                   rd_accept;
  logic                   wr_accept;
  logic                   lat_write;
  memsys_pkg::addr_t      lat_addr;
  memsys_pkg::data_t      lat_wdata;
  memsys_pkg::strb_t      lat_wstrb;
  memsys_pkg::id_t        lat_id;
  memsys_pkg::addr_t      sram_off;
  logic                   in_sram;

  // read wins when both channels are offered
  assign ar_ready_o = idle_q;
  assign aw_ready_o = idle_q & aw_valid_i & w_valid_i & ~ar_valid_i;
  assign w_ready_o  = aw_ready_o;
  assign rd_accept  = ar_valid_i & ar_ready_o;
  assign wr_accept  = aw_ready_o;

  always_comb begin
    state_d = state_q;
    case (state_q)
      memsys_pkg::DEC_IDLE:  if (rd_accept || wr_accept) state_d = memsys_pkg::DEC_ISSUE;
      memsys_pkg::DEC_ISSUE: state_d = memsys_pkg::DEC_WAIT;
      memsys_pkg::DEC_WAIT:  if (rsp_done_i) state_d = memsys_pkg::DEC_IDLE;
      default:               state_d = memsys_pkg::DEC_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= memsys_pkg::DEC_IDLE;
      idle_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      idle_q  <= (state_d == memsys_pkg::DEC_IDLE);
    end
  end

  // capture the accepted transaction
  always_ff @(posedge clk) begin
    if (rd_accept) begin
      lat_write <= 1'b0;
      lat_addr  <= ar_addr_i;
      lat_wstrb <= '0;
      lat_id    <= ar_id_i;
    end else if (wr_accept) begin
      lat_write <= 1'b1;
      lat_addr  <= aw_addr_i;
      lat_wdata <= w_data_i;
      lat_wstrb <= w_strb_i;
      lat_id    <= aw_id_i;
    end
  end

  // region classification
  assign sram_off = lat_addr - memsys_pkg::SRAM_BASE;
  assign in_sram  = (lat_addr >= memsys_pkg::SRAM_BASE) &&
                    ((sram_off >> 2) < memsys_pkg::addr_t'(MEM_WORDS));

  assign req.req_valid  = (state_q == memsys_pkg::DEC_ISSUE);
  assign req.req_write  = lat_write;
  assign req.req_region = in_sram ? memsys_pkg::REGION_SRAM :
                          (lat_addr == memsys_pkg::UART_TX_ADDR) ? memsys_pkg::REGION_UART :
                          memsys_pkg::REGION_NONE;
  assign req.req_index  = sram_off[IDX_W+1:2];
  assign req.req_wdata  = lat_wdata;
  assign req.req_wstrb  = lat_wstrb;
  assign req.req_id     = lat_id;

endmodule

// ==== rtl/mem_rsp_if.sv ====
interface mem_rsp_if;

  logic              rsp_valid;
  logic              rsp_write;
  memsys_pkg::data_t rsp_rdata;
  memsys_pkg::resp_t rsp_resp;
  memsys_pkg::id_t   rsp_id;

  // execute side
  modport master (
    output rsp_valid, rsp_write, rsp_rdata, rsp_resp, rsp_id
  );

  // response side
  modport slave (
    input rsp_valid, rsp_write, rsp_rdata, rsp_resp, rsp_id
  );

endinterface

// ==== rtl/mem_req_if.sv ====
interface mem_req_if #(
  parameter int MEM_WORDS = 256
);
  localparam int IDX_W = $clog2(MEM_WORDS);

  logic                req_valid;
  logic                req_write;
  memsys_pkg::region_e req_region;
  logic [IDX_W-1:0]    req_index;
  memsys_pkg::data_t   req_wdata;
  memsys_pkg::strb_t   req_wstrb;
  memsys_pkg::id_t     req_id;

  modport master (
    output req_valid, req_write, req_region, req_index, req_wdata, req_wstrb, req_id
  );

  modport slave (
    input req_valid, req_write, req_region, req_index, req_wdata, req_wstrb, req_id
  );

endinterface

// ==== rtl/memsys_pkg.sv ====
package memsys_pkg;

  // bus field widths
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [3:0]  id_t;
  typedef logic [1:0]  resp_t;

  // response codes
  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_DECERR = 2'd3;

  // decoded access target
  typedef enum logic [1:0] {
    REGION_SRAM,
    REGION_UART,
    REGION_NONE
  } region_e;

  // address map
  localparam addr_t SRAM_BASE    = 32'h8000_0000;
  localparam addr_t UART_TX_ADDR = 32'hA000_03F8;

  // request decode FSM
  typedef enum logic [1:0] {
    DEC_IDLE,
    DEC_ISSUE,
    DEC_WAIT
  } dec_state_e;

  // access execution FSM
  typedef enum logic {
    EXEC_IDLE,
    EXEC_STALL
  } exec_state_e;

endpackage
